/* design/delay_pkg.sv */
package delay_pkg;

   // Stream sideband layout
   localparam int TUSER_WIDTH = 128;
   // Arrival stamp sits in the upper half of tuser
   localparam int TS_LSB = 64;
   localparam int TS_MSB = 127;

   // Free-running time base
   localparam int TIME_WIDTH = 64;

   // Each configuration register
   localparam int CFG_WIDTH = 32;

   // Gate FSM states
   typedef enum logic [1:0] {
      MODULE_HEADER = 2'd0,
      IN_PACKET     = 2'd1,
      DROP          = 2'd2
   } gate_state_t;

   // Register map, address 3 is unused and reads back as zero
   typedef enum logic [1:0] {
      ADDR_DELAY_LENGTH = 2'd0,
      ADDR_DROP_LOOP    = 2'd1,
      ADDR_DROP_COUNT   = 2'd2
   } reg_addr_t;

endpackage

/* design/arrival_stamper.sv */
module arrival_stamper (
   input  logic                              axi_aclk,
   input  logic                              axi_resetn,
   // Slave beat as seen at the input of the FIFO
   input  logic [delay_pkg::TUSER_WIDTH-1:0] s_axis_tuser,
   input  logic                              s_axis_tvalid,
   input  logic                              s_axis_tready,
   input  logic                              s_axis_tlast,
   // Stamped sideband towards FIFO din
   output logic [delay_pkg::TUSER_WIDTH-1:0] stamped_tuser,
   // Current time base for the gate
   output logic [delay_pkg::TIME_WIDTH-1:0]  now
);

   import delay_pkg::*;

   // Beat accepted on the slave side
   logic                  accept;
   // High between first and last beat of a packet
   logic                  in_pkt;
   // Stamp taken on the first beat
   logic [TIME_WIDTH-1:0] stamp_q;

   assign accept = s_axis_tvalid & s_axis_tready;

   // Time base, zero in the first cycle out of reset
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         now <= '0;
      end else begin
         now <= now + 1'b1;
      end
   end

   // Packet tracking
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         in_pkt <= 1'b0;
      end else if (accept) begin
         // last beat closes the packet, any other beat keeps it open
         in_pkt <= ~s_axis_tlast;
      end
   end

   // Hold stamp for the remaining beats
   always_ff @(posedge axi_aclk) begin
      if (accept && !in_pkt) begin
         stamp_q <= now;
      end
   end

   // Replace upper tuser field, lower bits pass unchanged
   always_comb begin
      stamped_tuser = s_axis_tuser;
      // First beat gets the live time base
      stamped_tuser[TS_MSB:TS_LSB] = in_pkt ? stamp_q : now;
   end

endmodule

/* design/packet_fifo.sv */
module packet_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_BITS = 2
) (
   input  logic             axi_aclk,
   input  logic             axi_resetn,
   input  logic [WIDTH-1:0] din,
   input  logic             wr_en,
   input  logic             rd_en,
   // Head entry, valid whenever not empty
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             nearly_full
);

   localparam int DEPTH = 2 ** DEPTH_BITS;

   // Storage
   logic [WIDTH-1:0]      mem [DEPTH];
   // Ring pointers
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   // Occupancy, one extra bit to reach DEPTH
   logic [DEPTH_BITS:0]   count;

   // Write side
   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   // Pointer update
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy count
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         count <= '0;
      end else begin
         case ({wr_en, rd_en})
            // Write only
            2'b10: count <= count + 1'b1;
            // Read only
            2'b01: count <= count - 1'b1;
            // Both or neither leave it unchanged
            default: count <= count;
         endcase
      end
   end

   // Fall-through head, written entry shows up one cycle later
   assign dout  = mem[rd_ptr];
   assign empty = (count == '0);

   // At most one free slot left
   assign nearly_full = (count >= (DEPTH_BITS + 1)'(DEPTH - 1));

endmodule

/* design/delay_gate.sv */
module delay_gate (
   input  logic                              axi_aclk,
   input  logic                              axi_resetn,
   // Time base from the stamper
   input  logic [delay_pkg::TIME_WIDTH-1:0]  now,
   // Head of the FIFO
   input  logic [delay_pkg::TUSER_WIDTH-1:0] head_tuser,
   input  logic                              head_tlast,
   input  logic                              fifo_empty,
   input  logic                              m_axis_tready,
   // Configuration
   input  logic [delay_pkg::CFG_WIDTH-1:0]   delay_length,
   input  logic [delay_pkg::CFG_WIDTH-1:0]   drop_loop,
   input  logic [delay_pkg::CFG_WIDTH-1:0]   drop_count,
   output logic                              rd_en,
   output logic                              m_axis_tvalid
);

   import delay_pkg::*;

   gate_state_t           state;
   gate_state_t           state_next;
   // Drop loop counter
   logic [CFG_WIDTH-1:0]  drop_counter;
   logic [CFG_WIDTH-1:0]  drop_counter_next;
   // Earliest release time of head packet, minus one
   logic [TIME_WIDTH-1:0] release_time;

   // Stamp plus zero-extended delay
   assign release_time = head_tuser[TS_MSB:TS_LSB]
                       + {{(TIME_WIDTH - CFG_WIDTH){1'b0}}, delay_length};

   always_comb begin
      state_next        = state;
      drop_counter_next = drop_counter;
      rd_en             = 1'b0;
      m_axis_tvalid     = 1'b0;

      case (state)
         MODULE_HEADER: begin
            // Wait for the head packet to age past its delay
            if (!fifo_empty && (now > release_time)) begin
               // Drop share of the loop
               if (drop_counter < drop_count) begin
                  state_next = DROP;
               end else begin
                  state_next = IN_PACKET;
               end
               // Counter wraps to drop_loop after zero
               if (drop_counter == '0) begin
                  drop_counter_next = drop_loop;
               end else begin
                  drop_counter_next = drop_counter - 1'b1;
               end
            end
         end

         IN_PACKET: begin
            if (!fifo_empty) begin
               m_axis_tvalid = 1'b1;
               // Pop only on transfer
               if (m_axis_tready) begin
                  rd_en = 1'b1;
                  if (head_tlast) begin
                     state_next = MODULE_HEADER;
                  end
               end
            end
         end

         DROP: begin
            // One beat discarded per cycle
            if (!fifo_empty) begin
               rd_en = 1'b1;
               if (head_tlast) begin
                  state_next = MODULE_HEADER;
               end
            end
         end

         // Unused encoding
         default: state_next = MODULE_HEADER;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state        <= MODULE_HEADER;
         drop_counter <= '0;
      end else begin
         state        <= state_next;
         drop_counter <= drop_counter_next;
      end
   end

endmodule

/* design/delay_regs.sv */
module delay_regs (
   input  logic                            axi_aclk,
   input  logic                            axi_resetn,
   // Write strobe with address and data
   input  logic                            reg_wr_en,
   input  delay_pkg::reg_addr_t            reg_addr,
   input  logic [delay_pkg::CFG_WIDTH-1:0] reg_wr_data,
   // Combinational read-back
   output logic [delay_pkg::CFG_WIDTH-1:0] reg_rd_data,
   // Register values to the gate
   output logic [delay_pkg::CFG_WIDTH-1:0] delay_length,
   output logic [delay_pkg::CFG_WIDTH-1:0] drop_loop,
   output logic [delay_pkg::CFG_WIDTH-1:0] drop_count
);

   import delay_pkg::*;

   // Register writes, visible next cycle
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         delay_length <= '0;
         drop_loop    <= '0;
         drop_count   <= '0;
      end else if (reg_wr_en) begin
         case (reg_addr)
            ADDR_DELAY_LENGTH: delay_length <= reg_wr_data;
            ADDR_DROP_LOOP:    drop_loop    <= reg_wr_data;
            ADDR_DROP_COUNT:   drop_count   <= reg_wr_data;
            // Unused address, write ignored
            default: ;
         endcase
      end
   end

   // Address decode for read-back
   always_comb begin
      case (reg_addr)
         ADDR_DELAY_LENGTH: reg_rd_data = delay_length;
         ADDR_DROP_LOOP:    reg_rd_data = drop_loop;
         ADDR_DROP_COUNT:   reg_rd_data = drop_count;
         // Unused address reads as zero
         default:           reg_rd_data = '0;
      endcase
   end

endmodule

/* design/packet_delay_top.sv */
module packet_delay_top #(
   parameter int DATA_WIDTH      = 64,
   parameter int FIFO_DEPTH_BITS = 2
) (
   input  logic                              axi_aclk,
   input  logic                              axi_resetn,
   // Slave stream
   input  logic [DATA_WIDTH-1:0]             s_axis_tdata,
   input  logic [DATA_WIDTH/8-1:0]           s_axis_tstrb,
   input  logic [delay_pkg::TUSER_WIDTH-1:0] s_axis_tuser,
   input  logic                              s_axis_tvalid,
   output logic                              s_axis_tready,
   input  logic                              s_axis_tlast,
   // Master stream
   output logic [DATA_WIDTH-1:0]             m_axis_tdata,
   output logic [DATA_WIDTH/8-1:0]           m_axis_tstrb,
   output logic [delay_pkg::TUSER_WIDTH-1:0] m_axis_tuser,
   output logic                              m_axis_tvalid,
   input  logic                              m_axis_tready,
   output logic                              m_axis_tlast,
   // Register port
   input  logic                              reg_wr_en,
   input  delay_pkg::reg_addr_t              reg_addr,
   input  logic [delay_pkg::CFG_WIDTH-1:0]   reg_wr_data,
   output logic [delay_pkg::CFG_WIDTH-1:0]   reg_rd_data
);

   import delay_pkg::*;

   // Packed beat: last, tuser, tstrb, tdata
   localparam int FIFO_WIDTH = DATA_WIDTH + TUSER_WIDTH + DATA_WIDTH / 8 + 1;

   logic [TUSER_WIDTH-1:0] stamped_tuser;
   logic [TIME_WIDTH-1:0]  now;
   logic                   fifo_wr_en;
   logic                   fifo_rd_en;
   logic                   fifo_empty;
   logic                   fifo_nearly_full;
   logic [CFG_WIDTH-1:0]   delay_length;
   logic [CFG_WIDTH-1:0]   drop_loop;
   logic [CFG_WIDTH-1:0]   drop_count;

   // Ready while the FIFO has room
   assign s_axis_tready = ~fifo_nearly_full;
   assign fifo_wr_en    = s_axis_tvalid & s_axis_tready;

   arrival_stamper arrival_stamper_inst (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tlast  (s_axis_tlast),
      .stamped_tuser (stamped_tuser),
      .now           (now)
   );

   // FIFO head feeds the master stream directly
   packet_fifo #(
      .WIDTH      (FIFO_WIDTH),
      .DEPTH_BITS (FIFO_DEPTH_BITS)
   ) packet_fifo_inst (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         ({s_axis_tlast, stamped_tuser, s_axis_tstrb, s_axis_tdata}),
      .wr_en       (fifo_wr_en),
      .rd_en       (fifo_rd_en),
      .dout        ({m_axis_tlast, m_axis_tuser, m_axis_tstrb, m_axis_tdata}),
      .empty       (fifo_empty),
      .nearly_full (fifo_nearly_full)
   );

   delay_gate delay_gate_inst (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .now           (now),
      .head_tuser    (m_axis_tuser),
      .head_tlast    (m_axis_tlast),
      .fifo_empty    (fifo_empty),
      .m_axis_tready (m_axis_tready),
      .delay_length  (delay_length),
      .drop_loop     (drop_loop),
      .drop_count    (drop_count),
      .rd_en         (fifo_rd_en),
      .m_axis_tvalid (m_axis_tvalid)
   );

   delay_regs delay_regs_inst (
      .axi_aclk     (axi_aclk),
      .axi_resetn   (axi_resetn),
      .reg_wr_en    (reg_wr_en),
      .reg_addr     (reg_addr),
      .reg_wr_data  (reg_wr_data),
      .reg_rd_data  (reg_rd_data),
      .delay_length (delay_length),
      .drop_loop    (drop_loop),
      .drop_count   (drop_count)
   );

endmodule

/* bench/packet_delay_assert.sv */
module packet_delay_assert #(
   parameter int DATA_WIDTH      = 64,
   parameter int FIFO_DEPTH_BITS = 2
) (
   input logic                              axi_aclk,
   input logic                              axi_resetn,
   // Gate side
   input delay_pkg::gate_state_t            state,
   input logic                              m_axis_tvalid,
   input logic                              m_axis_tready,
   input logic [DATA_WIDTH-1:0]             m_axis_tdata,
   input logic [DATA_WIDTH/8-1:0]           m_axis_tstrb,
   input logic [delay_pkg::TUSER_WIDTH-1:0] m_axis_tuser,
   input logic                              m_axis_tlast,
   // FIFO side
   input logic                              fifo_wr_en,
   input logic                              fifo_rd_en,
   input logic                              fifo_empty,
   input logic [FIFO_DEPTH_BITS:0]          fifo_count
);

   timeunit 1ns;
   timeprecision 1ps;

   import delay_pkg::*;

   localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

   // Valid only while forwarding
   tvalid_in_packet: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid |-> (state == IN_PACKET))
      else $error("m_axis_tvalid high outside IN_PACKET");

   // Stalled beat must not change
   held_beat_stable: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=>
         (m_axis_tvalid && $stable({m_axis_tlast, m_axis_tuser, m_axis_tstrb, m_axis_tdata})))
      else $error("master beat changed while stalled");

   // Overflow would overwrite the head entry
   no_write_when_full: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      fifo_wr_en |-> (fifo_count != (FIFO_DEPTH_BITS + 1)'(DEPTH)))
      else $error("FIFO written while full");

   no_read_when_empty: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      fifo_rd_en |-> !fifo_empty)
      else $error("FIFO read while empty");

endmodule

// Gate and FIFO signals reached from the top level
bind packet_delay_top packet_delay_assert #(
   .DATA_WIDTH      (DATA_WIDTH),
   .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
) packet_delay_assert_inst (
   .axi_aclk      (axi_aclk),
   .axi_resetn    (axi_resetn),
   .state         (delay_gate_inst.state),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready),
   .m_axis_tdata  (m_axis_tdata),
   .m_axis_tstrb  (m_axis_tstrb),
   .m_axis_tuser  (m_axis_tuser),
   .m_axis_tlast  (m_axis_tlast),
   .fifo_wr_en    (fifo_wr_en),
   .fifo_rd_en    (fifo_rd_en),
   .fifo_empty    (fifo_empty),
   .fifo_count    (packet_fifo_inst.count)
);

/* bench/packet_delay_tb.sv */
module packet_delay_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import delay_pkg::*;

   localparam int DATA_WIDTH      = 64;
   localparam int STRB_WIDTH      = DATA_WIDTH / 8;
   localparam int FIFO_DEPTH_BITS = 2;
   // Traffic size, sets the timeout
   localparam int NUM_PKTS       = 42;
   localparam int MAX_LEN        = 8;
   localparam int MAX_DELAY      = 13;
   localparam int TIMEOUT_CYCLES = NUM_PKTS * (MAX_LEN + MAX_DELAY + 10) * 4;

   // One expected output beat
   typedef struct packed {
      logic [DATA_WIDTH-1:0]  data;
      logic [STRB_WIDTH-1:0]  strb;
      logic [TUSER_WIDTH-1:0] user;
      logic                   last;
      logic                   first;
      logic [TIME_WIDTH-1:0]  in_cycle;
   } beat_t;

   logic                   axi_aclk;
   logic                   axi_resetn;
   logic [DATA_WIDTH-1:0]  s_axis_tdata;
   logic [STRB_WIDTH-1:0]  s_axis_tstrb;
   logic [TUSER_WIDTH-1:0] s_axis_tuser;
   logic                   s_axis_tvalid;
   logic                   s_axis_tready;
   logic                   s_axis_tlast;
   logic [DATA_WIDTH-1:0]  m_axis_tdata;
   logic [STRB_WIDTH-1:0]  m_axis_tstrb;
   logic [TUSER_WIDTH-1:0] m_axis_tuser;
   logic                   m_axis_tvalid;
   logic                   m_axis_tready;
   logic                   m_axis_tlast;
   logic                   reg_wr_en;
   reg_addr_t              reg_addr;
   logic [CFG_WIDTH-1:0]   reg_wr_data;
   logic [CFG_WIDTH-1:0]   reg_rd_data;

   int seed = 43;
   int ready_seed;
   int error_count = 0;
   int run_cycles = 0;
   // Same count as the DUT time base
   logic [TIME_WIDTH-1:0]  cycle_now;
   // Settings of the running test
   logic [CFG_WIDTH-1:0]   cur_delay;
   logic [CFG_WIDTH-1:0]   cur_loop;
   logic [CFG_WIDTH-1:0]   cur_count;
   bit                     bp_on;
   // Input side tracking
   bit                     in_pkt;
   bit                     pkt_fwd;
   int unsigned            pkt_seq;
   logic [TIME_WIDTH-1:0]  pkt_stamp;
   beat_t                  in_beat;
   beat_t                  out_beat;
   beat_t                  exp_q[$];

   packet_delay_top #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
   ) packet_delay_top_inst (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tlast  (s_axis_tlast),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tlast  (m_axis_tlast),
      .reg_wr_en     (reg_wr_en),
      .reg_addr      (reg_addr),
      .reg_wr_data   (reg_wr_data),
      .reg_rd_data   (reg_rd_data)
   );

   always #10 axi_aclk = ~axi_aclk;

   // Zero in the first cycle after reset, like the DUT
   always @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         cycle_now <= '0;
      end else begin
         cycle_now <= cycle_now + 64'd1;
      end
   end

   task automatic report_failure(input string msg);
      error_count++;
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped at first error");
   endtask

   always @(posedge axi_aclk) begin
      run_cycles++;
      if (run_cycles >= TIMEOUT_CYCLES) begin
         report_failure($sformatf("timeout after %0d cycles, traffic did not finish",
                                  run_cycles));
      end
   end

   // Counter runs 0, loop, loop-1 .. 1, 0; packets below count are dropped
   function automatic bit is_forwarded(input int unsigned seq,
                                       input logic [CFG_WIDTH-1:0] loop,
                                       input logic [CFG_WIDTH-1:0] count);
      logic [63:0] period;
      logic [63:0] counter;
      period  = {32'd0, loop} + 64'd1;
      counter = (period - ({32'd0, seq} % period)) % period;
      return counter >= {32'd0, count};
   endfunction

   task automatic check_beat(input logic [DATA_WIDTH-1:0] data,
                             input logic [STRB_WIDTH-1:0] strb,
                             input logic [TUSER_WIDTH-1:0] user,
                             input logic last,
                             input beat_t exp);
      if (data !== exp.data) begin
         report_failure($sformatf("error at %0t: m_axis_tdata got %h expected %h",
                                  $time, data, exp.data));
      end
      if (strb !== exp.strb) begin
         report_failure($sformatf("error at %0t: m_axis_tstrb got %h expected %h",
                                  $time, strb, exp.strb));
      end
      if (user !== exp.user) begin
         report_failure($sformatf("error at %0t: m_axis_tuser got %h expected %h",
                                  $time, user, exp.user));
      end
      if (last !== exp.last) begin
         report_failure($sformatf("error at %0t: m_axis_tlast got %b expected %b",
                                  $time, last, exp.last));
      end
   endtask

   task automatic check_reg(input string name,
                            input logic [CFG_WIDTH-1:0] got,
                            input logic [CFG_WIDTH-1:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("error at %0t: reg_rd_data (%s) got %h expected %h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_delay(input logic [TIME_WIDTH-1:0] latency,
                              input logic [TIME_WIDTH-1:0] min_latency);
      if (latency < min_latency) begin
         report_failure($sformatf("error at %0t: first beat latency got %0d expected >= %0d",
                                  $time, latency, min_latency));
      end
   endtask

   // Record accepted beats of forwarded packets
   always @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         in_pkt  = 1'b0;
         pkt_seq = 0;
         exp_q.delete();
      end else if (s_axis_tvalid && s_axis_tready) begin
         if (!in_pkt) begin
            pkt_stamp = cycle_now;
            pkt_fwd   = is_forwarded(pkt_seq, cur_loop, cur_count);
            pkt_seq++;
         end
         if (pkt_fwd) begin
            in_beat.data     = s_axis_tdata;
            in_beat.strb     = s_axis_tstrb;
            in_beat.user     = {pkt_stamp, s_axis_tuser[TS_LSB-1:0]};
            in_beat.last     = s_axis_tlast;
            in_beat.first    = !in_pkt;
            in_beat.in_cycle = pkt_stamp;
            exp_q.push_back(in_beat);
         end
         in_pkt = !s_axis_tlast;
      end
   end

   // Compare every master transfer against the queue
   always @(posedge axi_aclk) begin
      if (axi_resetn) begin
         if (packet_delay_top_inst.fifo_wr_en && !s_axis_tready) begin
            report_failure("an input beat went into the FIFO while s_axis_tready was low");
         end
         if (m_axis_tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
               report_failure("an output beat appeared with no forwarded packet pending");
            end else begin
               out_beat = exp_q.pop_front();
               check_beat(m_axis_tdata, m_axis_tstrb, m_axis_tuser, m_axis_tlast, out_beat);
               if (out_beat.first) begin
                  check_delay(cycle_now - out_beat.in_cycle, {32'd0, cur_delay} + 64'd2);
               end
            end
         end
      end
   end

   // Output ready, random under back-pressure
   always @(posedge axi_aclk) begin
      #2;
      if (bp_on) begin
         m_axis_tready = ($random(ready_seed) & 3) != 0;
      end else begin
         m_axis_tready = 1'b1;
      end
   end

   task automatic apply_reset();
      axi_resetn = 1'b0;
      repeat (10) @(posedge axi_aclk);
      #2;
      axi_resetn = 1'b1;
   endtask

   task automatic write_reg(input reg_addr_t addr, input logic [CFG_WIDTH-1:0] data);
      reg_wr_en   = 1'b1;
      reg_addr    = addr;
      reg_wr_data = data;
      @(posedge axi_aclk);
      #2;
      reg_wr_en = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr,
                           input logic [CFG_WIDTH-1:0] exp,
                           input string name);
      reg_addr = addr;
      // Read port is combinational
      #1;
      check_reg(name, reg_rd_data, exp);
      @(posedge axi_aclk);
      #2;
   endtask

   task automatic configure(input logic [CFG_WIDTH-1:0] delay,
                            input logic [CFG_WIDTH-1:0] loop,
                            input logic [CFG_WIDTH-1:0] count);
      cur_delay = delay;
      cur_loop  = loop;
      cur_count = count;
      write_reg(ADDR_DELAY_LENGTH, delay);
      write_reg(ADDR_DROP_LOOP, loop);
      write_reg(ADDR_DROP_COUNT, count);
   endtask

   task automatic send_packet(input int len, input bit gaps);
      bit accepted;
      for (int i = 0; i < len; i++) begin
         // Random idle cycles before the beat
         while (gaps && (($random(seed) & 3) == 0)) begin
            s_axis_tvalid = 1'b0;
            @(posedge axi_aclk);
            #2;
         end
         s_axis_tdata  = {$random(seed), $random(seed)};
         s_axis_tstrb  = STRB_WIDTH'($random(seed));
         s_axis_tuser  = {$random(seed), $random(seed), $random(seed), $random(seed)};
         s_axis_tlast  = (i == len - 1);
         s_axis_tvalid = 1'b1;
         // Hold until taken; tready is settled by now
         do begin
            accepted = s_axis_tready;
            @(posedge axi_aclk);
            #2;
         end while (!accepted);
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic send_burst(input int num, input bit gaps);
      int len;
      for (int n = 0; n < num; n++) begin
         len = int'($unsigned($random(seed)) % MAX_LEN) + 1;
         send_packet(len, gaps);
      end
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(posedge axi_aclk);
      end
      // Window for stray beats
      repeat (MAX_DELAY + MAX_LEN + 10) @(posedge axi_aclk);
      #2;
   endtask

   initial begin
      logic [CFG_WIDTH-1:0] wr_val [3];
      ready_seed    = seed + 1;
      axi_aclk      = 1'b0;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      m_axis_tready = 1'b1;
      reg_wr_en     = 1'b0;
      reg_addr      = ADDR_DELAY_LENGTH;
      reg_wr_data   = '0;
      cur_delay     = '0;
      cur_loop      = '0;
      cur_count     = '0;
      bp_on         = 1'b0;
      apply_reset();

      // Register read-back
      for (int i = 0; i < 3; i++) begin
         wr_val[i] = $random(seed);
      end
      write_reg(ADDR_DELAY_LENGTH, wr_val[0]);
      write_reg(ADDR_DROP_LOOP, wr_val[1]);
      write_reg(ADDR_DROP_COUNT, wr_val[2]);
      read_reg(ADDR_DELAY_LENGTH, wr_val[0], "delay_length");
      read_reg(ADDR_DROP_LOOP, wr_val[1], "drop_loop");
      read_reg(ADDR_DROP_COUNT, wr_val[2], "drop_count");
      read_reg(reg_addr_t'(2'd3), '0, "unused address");

      // Zero delay, nothing dropped
      apply_reset();
      configure(0, 0, 0);
      send_burst(8, 1'b0);
      drain();

      // Long delay, gaps on the input
      apply_reset();
      configure(MAX_DELAY, 0, 0);
      send_burst(6, 1'b1);
      drain();

      // Two of every four packets dropped
      apply_reset();
      configure(5, 3, 2);
      send_burst(12, 1'b0);
      drain();

      // Back-pressure with random input valid
      apply_reset();
      configure(2, 4, 1);
      bp_on = 1'b1;
      send_burst(16, 1'b1);
      drain();
      bp_on = 1'b0;

      if (error_count == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         report_failure("errors were counted during the run");
      end
   end

endmodule

/* project.f */
design/delay_pkg.sv
design/arrival_stamper.sv
design/packet_fifo.sv
design/delay_gate.sv
design/delay_regs.sv
design/packet_delay_top.sv
bench/packet_delay_assert.sv
bench/packet_delay_tb.sv

/* Makefile */
TOP = packet_delay_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f project.f -o sim_$(TOP)

# A crash or a failed assertion also counts as a failing run
run: compile
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1 || echo "FAIL: see errors above" >> $(LOG)
	cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
